// File: hw/texturePkg.sv
// Shared widths, size codes and the structs passed between the texture buffer blocks
// Bank word addresses travel at a fixed 15 bits; each block slices what its depth needs

package texturePkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    localparam int texelWidth    = 16;
    localparam int coordWidth    = 16;  // Q1.15 coordinates, Q0.16 sub-coordinates
    localparam int streamWidth   = 32;  // Two texels per beat
    localparam int wordAddrWidth = 15;

    typedef logic [texelWidth-1:0]    texel_t;
    typedef logic [wordAddrWidth-1:0] wordAddr_t;

    // Axis size, one-hot; all zero means a single texel
    typedef enum logic [7:0] {
        px1   = 8'h00,
        px2   = 8'h01,
        px4   = 8'h02,
        px8   = 8'h04,
        px16  = 8'h08,
        px32  = 8'h10,
        px64  = 8'h20,
        px128 = 8'h40,
        px256 = 8'h80
    } texSizeE;

    ////////////////////////////////////////
    // Structs
    ////////////////////////////////////////

    typedef struct packed {
        logic [coordWidth-1:0] s;       // Q1.15
        logic [coordWidth-1:0] t;       // Q1.15
        logic                  clampS;
        logic                  clampT;
    } texCoordS;

    // Linear texel addresses, index order is (t, s)
    typedef struct packed {
        logic [15:0] a00;
        logic [15:0] a01;
        logic [15:0] a10;
        logic [15:0] a11;
    } quadAddrS;

    typedef struct packed {
        logic [coordWidth-1:0] subS;    // Q0.16
        logic [coordWidth-1:0] subT;
    } subCoordS;

    typedef struct packed {
        texel_t t00;
        texel_t t01;
        texel_t t10;
        texel_t t11;
    } texelQuadS;

    typedef struct packed {
        logic      we;
        wordAddr_t addr;
        texel_t    evenTexel;
        texel_t    oddTexel;
    } bankWriteS;

endpackage

// File: hw/texelAddressGen.sv
// Builds the four quad addresses from (s, t); address output is combinational
// Clamp flags, sub-coordinates and a copy of the addresses are registered for the next stage
`timescale 1ns/1ns

module texelAddressGen
(
    input  logic                  aclk,
    input  logic                  resetn,
    input  texturePkg::texSizeE   sizeW,
    input  texturePkg::texSizeE   sizeH,
    input  texturePkg::texCoordS  coord,
    output texturePkg::quadAddrS  addr,
    output texturePkg::quadAddrS  addrReg,
    output logic                  clampS,
    output logic                  clampT,
    output texturePkg::subCoordS  sub
);

    logic [3:0]  kS;
    logic [3:0]  kT;
    logic [7:0]  idxS;
    logic [7:0]  nxtS;
    logic [7:0]  idxT;
    logic [7:0]  nxtT;
    logic [15:0] subS;
    logic [15:0] subT;
    logic        lastS;
    logic        lastT;

    // log2 of the axis size, 0 for a single texel
    function automatic logic [3:0] axisLog2(input texturePkg::texSizeE size);
        case (size)
            texturePkg::px2:   return 4'd1;
            texturePkg::px4:   return 4'd2;
            texturePkg::px8:   return 4'd3;
            texturePkg::px16:  return 4'd4;
            texturePkg::px32:  return 4'd5;
            texturePkg::px64:  return 4'd6;
            texturePkg::px128: return 4'd7;
            texturePkg::px256: return 4'd8;
            default:           return 4'd0;
        endcase
    endfunction

    // Index, wrapped neighbour and fraction of one axis
    function automatic void decodeAxis(
        input  logic [15:0] c,
        input  logic [3:0]  k,
        output logic [7:0]  idx,
        output logic [7:0]  nxt,
        output logic [15:0] subc
    );
        logic [7:0] mask;
        mask = 8'((9'd1 << k) - 9'd1);
        idx  = 8'(c[14:0] >> (4'd15 - k));   // k bits just below the integer bit
        nxt  = (idx + 8'd1) & mask;
        subc = (k == 4'd0) ? 16'h0 : 16'({c[14:0], 1'b0} << k);
    endfunction

    always_comb
    begin
        kS = axisLog2(sizeW);
        kT = axisLog2(sizeH);
        decodeAxis(coord.s, kS, idxS, nxtS, subS);
        decodeAxis(coord.t, kT, idxT, nxtT, subT);

        // Neighbour wrapped to zero means we sit on the last texel
        lastS = (kS != 4'd0) && (nxtS == 8'd0);
        lastT = (kT != 4'd0) && (nxtT == 8'd0);

        addr.a00 = (16'(idxT) << kS) | 16'(idxS);
        addr.a01 = (16'(idxT) << kS) | 16'(nxtS);
        addr.a10 = (16'(nxtT) << kS) | 16'(idxS);
        addr.a11 = (16'(nxtT) << kS) | 16'(nxtS);
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            clampS <= 1'b0;
            clampT <= 1'b0;
        end
        else
        begin
            clampS <= coord.clampS && lastS;
            clampT <= coord.clampT && lastT;
        end
    end

    always_ff @(posedge aclk)
    begin
        addrReg  <= addr;     // Parity bits pick the bank later
        sub.subS <= subS;
        sub.subT <= subT;
    end

    // Size codes must be one-hot or zero, otherwise the decode falls back to 1 texel
    assert property (@(posedge aclk) disable iff (!resetn)
        $onehot0(sizeW) && $onehot0(sizeH));

endmodule

// File: hw/texelBank.sv
// One half of the texel memory, 16-bit words, one-cycle read latency
// Port B carries the stream write when enabled; its row-1 read is lost in that cycle
`timescale 1ns/1ns

module texelBank #(
    parameter int sizeLog2 = 13     // Bytes per bank as a power of two
)
(
    input  logic                  aclk,
    input  texturePkg::bankWriteS wr,
    input  logic                  oddBank,
    input  logic [sizeLog2-2:0]   rowAddr0,
    input  logic [sizeLog2-2:0]   rowAddr1,
    output texturePkg::texel_t    rowData0,
    output texturePkg::texel_t    rowData1
);

    localparam int addrW = sizeLog2 - 1;
    localparam int depth = 2 ** addrW;

    texturePkg::texel_t mem [depth];
    texturePkg::texel_t wrTexel;

    // Pick our half of the beat
    assign wrTexel = oddBank ? wr.oddTexel : wr.evenTexel;

    ////////////////////////////////////////
    // Port A, row 0 read
    ////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        rowData0 <= mem[rowAddr0];
    end

    ////////////////////////////////////////
    // Port B, write wins over row 1
    ////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (wr.we)
        begin
            mem[wr.addr[addrW-1:0]] <= wrTexel;
        end
        else
        begin
            rowData1 <= mem[rowAddr1];
        end
    end

    // Writer must not address beyond this bank
    assert property (@(posedge aclk) wr.we |-> (wr.addr < depth));

endmodule

// File: hw/texelStreamWriter.sv
// 32-bit stream write port, no back-pressure; low half goes to the even bank
// Word counter restarts at 0 after every beat with tlast
`timescale 1ns/1ns

module texelStreamWriter #(
    parameter int sizeLog2 = 14     // Total texture memory in bytes, power of two
)
(
    input  logic                           aclk,
    input  logic                           resetn,
    input  logic                           tvalid,
    input  logic                           tlast,
    input  logic [texturePkg::streamWidth-1:0] tdata,
    output logic                           tready,
    output texturePkg::bankWriteS          wr
);

    localparam int cntW = sizeLog2 - 2;     // One word per bank per beat

    logic [cntW-1:0] wordCnt;
    logic            beat;

    assign beat = tvalid && tready;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            tready  <= 1'b0;
            wordCnt <= '0;
        end
        else
        begin
            tready <= 1'b1;
            if (beat)
            begin
                wordCnt <= tlast ? '0 : wordCnt + 1'b1;
            end
        end
    end

    // Bank write happens on the beat edge
    assign wr.we        = beat;
    assign wr.addr      = texturePkg::wordAddr_t'(wordCnt);
    assign wr.evenTexel = tdata[15:0];
    assign wr.oddTexel  = tdata[31:16];

    // A beat in the last word slot has to close the texture
    assert property (@(posedge aclk) disable iff (!resetn)
        (beat && !tlast) |-> (wordCnt != {cntW{1'b1}}));

endmodule

// File: hw/texelQuadSelect.sv
// Second stage: picks even or odd bank data by address parity and applies clamping
// Quad and sub-coordinates leave through one register
`timescale 1ns/1ns

module texelQuadSelect
(
    input  logic                  aclk,
    input  texturePkg::quadAddrS  addrReg,
    input  logic                  clampS,
    input  logic                  clampT,
    input  texturePkg::texel_t    evenData0,
    input  texturePkg::texel_t    oddData0,
    input  texturePkg::texel_t    evenData1,
    input  texturePkg::texel_t    oddData1,
    input  texturePkg::subCoordS  subIn,
    output texturePkg::texelQuadS quad,
    output texturePkg::subCoordS  sub
);

    texturePkg::texel_t sel00;
    texturePkg::texel_t sel01;
    texturePkg::texel_t sel10;
    texturePkg::texel_t sel11;
    texturePkg::texelQuadS quadNext;

    ////////////////////////////////////////
    // Bank demux
    ////////////////////////////////////////

    assign sel00 = addrReg.a00[0] ? oddData0 : evenData0;  // Row 0
    assign sel01 = addrReg.a01[0] ? oddData0 : evenData0;
    assign sel10 = addrReg.a10[0] ? oddData1 : evenData1;  // Row 1
    assign sel11 = addrReg.a11[0] ? oddData1 : evenData1;

    // Clamp substitution
    always_comb
    begin
        quadNext.t00 = sel00;
        quadNext.t01 = clampS ? sel00 : sel01;
        quadNext.t10 = clampT ? sel00 : sel10;
        if (clampS)
        begin
            quadNext.t11 = quadNext.t10;    // Follows the T clamp
        end
        else if (clampT)
        begin
            quadNext.t11 = sel01;
        end
        else
        begin
            quadNext.t11 = sel11;
        end
    end

    always_ff @(posedge aclk)
    begin
        quad <= quadNext;
        sub  <= subIn;
    end

endmodule

// File: hw/textureBuffer.sv
// Whole-texture buffer returning a 2x2 quad per cycle, two cycles of latency
// A read in the same cycle as a stream beat gets undefined row-1 texels
`timescale 1ns/1ns

module textureBuffer #(
    parameter int sizeLog2 = 14     // Total memory in bytes, 8192 texels at 14
)
(
    input  logic                               aclk,
    input  logic                               resetn,
    input  texturePkg::texSizeE                sizeW,
    input  texturePkg::texSizeE                sizeH,
    input  texturePkg::texCoordS               coord,
    output texturePkg::texelQuadS              quad,
    output texturePkg::subCoordS               sub,
    input  logic                               tvalid,
    output logic                               tready,
    input  logic                               tlast,
    input  logic [texturePkg::streamWidth-1:0] tdata
);

    localparam int bankAddrW = sizeLog2 - 2;

    texturePkg::bankWriteS wr;
    texturePkg::quadAddrS  addr;
    texturePkg::quadAddrS  addrReg;
    texturePkg::subCoordS  subReg;
    logic                  clampS;
    logic                  clampT;

    logic [bankAddrW-1:0]  evenAddr0;
    logic [bankAddrW-1:0]  oddAddr0;
    logic [bankAddrW-1:0]  evenAddr1;
    logic [bankAddrW-1:0]  oddAddr1;
    texturePkg::texel_t    evenData0;
    texturePkg::texel_t    oddData0;
    texturePkg::texel_t    evenData1;
    texturePkg::texel_t    oddData1;

    texelStreamWriter #(.sizeLog2(sizeLog2)) u_writer (
        .aclk(aclk), .resetn(resetn), .tvalid(tvalid), .tlast(tlast),
        .tdata(tdata), .tready(tready), .wr(wr)
    );

    texelAddressGen u_addrGen (
        .aclk(aclk), .resetn(resetn), .sizeW(sizeW), .sizeH(sizeH), .coord(coord),
        .addr(addr), .addrReg(addrReg), .clampS(clampS), .clampT(clampT), .sub(subReg)
    );

    ////////////////////////////////////////
    // Row steering by address parity
    ////////////////////////////////////////

    assign evenAddr0 = addr.a00[0] ? addr.a01[bankAddrW:1] : addr.a00[bankAddrW:1];
    assign oddAddr0  = addr.a00[0] ? addr.a00[bankAddrW:1] : addr.a01[bankAddrW:1];
    assign evenAddr1 = addr.a10[0] ? addr.a11[bankAddrW:1] : addr.a10[bankAddrW:1];
    assign oddAddr1  = addr.a10[0] ? addr.a10[bankAddrW:1] : addr.a11[bankAddrW:1];

    texelBank #(.sizeLog2(sizeLog2 - 1)) u_evenBank (
        .aclk(aclk), .wr(wr), .oddBank(1'b0),
        .rowAddr0(evenAddr0), .rowAddr1(evenAddr1),
        .rowData0(evenData0), .rowData1(evenData1)
    );

    texelBank #(.sizeLog2(sizeLog2 - 1)) u_oddBank (
        .aclk(aclk), .wr(wr), .oddBank(1'b1),
        .rowAddr0(oddAddr0), .rowAddr1(oddAddr1),
        .rowData0(oddData0), .rowData1(oddData1)
    );

    texelQuadSelect u_quadSelect (
        .aclk(aclk), .addrReg(addrReg), .clampS(clampS), .clampT(clampT),
        .evenData0(evenData0), .oddData0(oddData0),
        .evenData1(evenData1), .oddData1(oddData1),
        .subIn(subReg), .quad(quad), .sub(sub)
    );

endmodule

// File: test/textureModel.svh
// Texel memory mirror and quad lookup rules; holds linear texel addresses 0..8191
// Reads of texels that were never loaded return X
`ifndef TEXTURE_MODEL_SVH
`define TEXTURE_MODEL_SVH

texturePkg::texel_t modelMem [8192];

// Axis size code to log2 of texels, 0 for a single texel
function automatic int modelLog2(input texturePkg::texSizeE size);
    for (int i = 0; i < 8; i++)
    begin
        if (size[i])
            return i + 1;
    end
    return 0;
endfunction

function automatic int modelIndex(input logic [15:0] c, input int k);
    return (int'(c[14:0]) >> (15 - k)) & ((1 << k) - 1);   // k bits under the integer bit
endfunction

// Remaining fraction bits, left-aligned to 16
function automatic logic [15:0] modelFraction(input logic [15:0] c, input int k);
    logic [31:0] low;
    if (k == 0)
        return 16'h0;
    low = 32'(c[14:0]) & ((32'd1 << (15 - k)) - 32'd1);
    return 16'(low << (k + 1));
endfunction

function automatic texturePkg::subCoordS modelSub(input texturePkg::texCoordS c,
    input texturePkg::texSizeE w, input texturePkg::texSizeE h);
    texturePkg::subCoordS r;
    r.subS = modelFraction(c.s, modelLog2(w));
    r.subT = modelFraction(c.t, modelLog2(h));
    return r;
endfunction

function automatic texturePkg::texelQuadS modelQuad(input texturePkg::texCoordS c,
    input texturePkg::texSizeE w, input texturePkg::texSizeE h);
    texturePkg::texelQuadS q;
    int kS;
    int kT;
    int width;
    int height;
    int iS;
    int iT;
    int nS;
    int nT;
    bit cS;
    bit cT;
    kS     = modelLog2(w);
    kT     = modelLog2(h);
    width  = 1 << kS;
    height = 1 << kT;
    iS     = modelIndex(c.s, kS);
    iT     = modelIndex(c.t, kT);
    nS     = (iS + 1) % width;      // Repeat wrap
    nT     = (iT + 1) % height;
    cS     = c.clampS && (kS != 0) && (iS == width - 1);
    cT     = c.clampT && (kT != 0) && (iT == height - 1);
    q.t00  = modelMem[iT * width + iS];
    q.t01  = modelMem[iT * width + nS];
    q.t10  = modelMem[nT * width + iS];
    q.t11  = modelMem[nT * width + nS];
    if (cT)
    begin
        q.t10 = q.t00;
        if (!cS)
            q.t11 = q.t01;
    end
    if (cS)
    begin
        q.t01 = q.t00;
        q.t11 = q.t10;      // Already T clamped
    end
    return q;
endfunction

`endif

// File: test/textureBufferTb.sv
// Random loads and quad reads on textureBuffer, checked against the texel model
// Reads never overlap stream beats, so row-1 data is always defined
`timescale 1ns/1ns

module textureBufferTb;

    localparam int readsPerPhase  = 200;
    localparam int totalBeats     = 256 + 1 + 256 + 128 + 5 + 256;
    localparam int totalReads     = readsPerPhase * 6;
    localparam int watchdogCycles = totalBeats + totalReads + 100;

    logic                  aclk;
    logic                  resetn;
    texturePkg::texSizeE   sizeW;
    texturePkg::texSizeE   sizeH;
    texturePkg::texCoordS  coord;
    texturePkg::texelQuadS quad;
    texturePkg::subCoordS  sub;
    logic                  tvalid;
    logic                  tready;
    logic                  tlast;
    logic [31:0]           tdata;

    logic [31:0]           rngState = 32'h149e_a1de;
    texturePkg::texelQuadS expQuad[$];
    texturePkg::subCoordS  expSub[$];

    `include "textureModel.svh"

    textureBuffer #(.sizeLog2(14)) u_textureBuffer (
        .aclk(aclk), .resetn(resetn), .sizeW(sizeW), .sizeH(sizeH), .coord(coord),
        .quad(quad), .sub(sub), .tvalid(tvalid), .tready(tready), .tlast(tlast),
        .tdata(tdata)
    );

    initial
    begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Coordinate bits that put the index on the last texel
    function automatic logic [15:0] lastIndexBits(input int k);
        return 16'(((1 << k) - 1) << (15 - k));
    endfunction

    task automatic nextCycle();
        @(posedge aclk);
        #2;
    endtask

    task automatic checkValue(input string testName, input logic [63:0] expected,
        input logic [63:0] actual);
        if (actual !== expected)
        begin
            $display("** Error %s: expected %h, actual %h", testName, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Mismatch in %s", testName);
        end
    endtask

    task automatic checkOldest(input string testName);
        texturePkg::texelQuadS q;
        texturePkg::subCoordS  s;
        q = expQuad.pop_front();
        s = expSub.pop_front();
        checkValue({testName, " quad"}, q, quad);
        checkValue({testName, " sub"}, 64'(s), 64'(sub));
    endtask

    // Streams texels from address 0 up, closing with tlast
    task automatic loadTexture(input int texels);
        int          beats;
        logic [31:0] data;
        beats = (texels + 1) / 2;
        for (int i = 0; i < beats; i++)
        begin
            nextCycle();
            data   = nextRandom();
            tvalid = 1'b1;
            tlast  = (i == beats - 1);
            tdata  = data;
            modelMem[2 * i]     = data[15:0];    // Low half, even texel
            modelMem[2 * i + 1] = data[31:16];
        end
        nextCycle();
        tvalid = 1'b0;
        tlast  = 1'b0;
    endtask

    task automatic runReads(input string testName, input int count, input bit useClamp);
        texturePkg::texCoordS c;
        logic [31:0]          r;
        bit                   edgeS;
        bit                   edgeT;
        for (int i = 0; i < count; i++)
        begin
            nextCycle();
            if (expQuad.size() == 2)
                checkOldest(testName);
            r   = nextRandom();
            c.s = r[15:0];
            c.t = r[31:16];
            r   = nextRandom();
            edgeS = useClamp ? r[0] : (r[1:0] == 2'b00);   // Favor the wrap/clamp edge
            edgeT = useClamp ? r[1] : (r[3:2] == 2'b00);
            if (edgeS)
                c.s = c.s | lastIndexBits(modelLog2(sizeW));
            if (edgeT)
                c.t = c.t | lastIndexBits(modelLog2(sizeH));
            c.clampS = useClamp && r[4];
            c.clampT = useClamp && r[5];
            coord    = c;
            expQuad.push_back(modelQuad(c, sizeW, sizeH));
            expSub.push_back(modelSub(c, sizeW, sizeH));
        end
        while (expQuad.size() > 0)
        begin
            nextCycle();
            checkOldest(testName);
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        resetn = 1'b0;
        tvalid = 1'b0;
        tlast  = 1'b0;
        tdata  = '0;
        coord  = '0;
        sizeW  = texturePkg::px32;
        sizeH  = texturePkg::px16;

        repeat (5)
        begin
            nextCycle();
            checkValue("reset tready", 64'd0, 64'(tready));
        end
        resetn = 1'b1;
        nextCycle();
        checkValue("tready after reset", 64'd1, 64'(tready));

        loadTexture(32 * 16);
        runReads("quadRead", readsPerPhase, 1'b0);
        runReads("clampRead", readsPerPhase, 1'b1);

        sizeW = texturePkg::px1;
        sizeH = texturePkg::px1;
        loadTexture(1);
        runReads("size1x1", readsPerPhase, 1'b1);

        sizeW = texturePkg::px2;
        sizeH = texturePkg::px256;
        loadTexture(2 * 256);
        runReads("size2x256", readsPerPhase, 1'b1);

        sizeW = texturePkg::px256;
        sizeH = texturePkg::px1;
        loadTexture(256);
        runReads("size256x1", readsPerPhase, 1'b1);

        // Short load, then a full one that has to start over at word 0
        sizeW = texturePkg::px32;
        sizeH = texturePkg::px16;
        loadTexture(10);
        loadTexture(32 * 16);
        runReads("restart", readsPerPhase, 1'b1);

        $display("Simulation PASSED");
        $finish;
    end

    initial
    begin
        repeat (watchdogCycles) @(posedge aclk);
        $display("Watchdog: the tests did not finish within %0d cycles", watchdogCycles);
        $display("Simulation FAILED");
        $fatal(1, "Timeout");
    end

endmodule

// File: filelist.f
+incdir+test
hw/texturePkg.sv
hw/texelAddressGen.sv
hw/texelBank.sv
hw/texelStreamWriter.sv
hw/texelQuadSelect.sv
hw/textureBuffer.sv
test/textureBufferTb.sv

// File: run.sh
#!/bin/sh
# Builds the texture buffer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module textureBufferTb -f filelist.f -o textureBufferSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/textureBufferSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1
